//--- vector_lsu.f
+incdir+verilog
verilog/vector_lsu_pkg.sv
verilog/lsu_if.sv
verilog/lsu_decode.sv
verilog/lsu_sequencer.sv
verilog/lsu_store_lane.sv
verilog/lsu_load_gather.sv
verilog/vector_lsu.sv
bench/tb_vector_lsu.sv

//--- Makefile
# Verilator flow for the vector load/store unit
# Run from the project root, the testbench opens bench/lsu_input.txt

VERILATOR ?= verilator
TB_TOP    ?= tb_vector_lsu
RTL_TOP   ?= vector_lsu
FILELIST  ?= vector_lsu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 4

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass only when the testbench prints its pass line
sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/lsu_input.txt
# instr    base     stride   index_vector     write_vector     vl vm mask expected_read_data
# All fields hex, expected_read_data is ignored for stores
# Unit-stride loads
00000007 00000000 00000000 0000000000000000 0000000000000000 8 1 00 5d5c5f5e59585b5a
00005007 00000010 00000000 0000000000000000 0000000000000000 4 1 00 4d4c4f4e49484b4a
00006007 00000020 00000000 0000000000000000 0000000000000000 2 1 00 7d7c7f7e79787b7a
00000007 00000043 00000000 0000000000000000 0000000000000000 3 1 00 00000000001f1e19
# Strided and indexed loads, partial masks
08000007 00000080 00000003 0000000000000000 0000000000000000 6 0 2d 0000d500d3dc00da
08005007 00000090 00000006 0000000000000000 0000000000000000 4 0 0b f9f80000cdcccbca
08006007 00000048 fffffff8 0000000000000000 0000000000000000 2 1 00 19181b1a11101312
04000007 000000c0 00000000 0000050b0007020f 0000000000000000 6 0 37 00009f91009d9895
0c005007 000000a0 00000000 000200080004000e 0000000000000000 4 0 06 0000f3f2fffe0000
04006007 00000080 00000000 000000040000000c 0000000000000000 2 1 00 dddcdfded5d4d7d6
# Stores, each followed by a read back
08000027 00000030 00000002 0000000000000000 00000000d4c3b2a1 4 0 05 0000000000000000
00000007 00000030 00000000 0000000000000000 0000000000000000 8 1 00 6d6c6fc369686ba1
08005027 00000060 00000004 0000000000000000 56781234cafebeef 3 0 05 0000000000000000
00005007 00000060 00000000 0000000000000000 0000000000000000 4 1 00 3d3c3f3e3938beef
00006007 00000068 00000000 0000000000000000 0000000000000000 1 1 00 0000000031301234
00006027 00000050 00000000 0000000000000000 0123456789abcdef 2 1 00 0000000000000000
00000007 00000050 00000000 0000000000000000 0000000000000000 8 1 00 0123456789abcdef
# vl above the register capacity
00006007 00000020 00000000 0000000000000000 0000000000000000 f 1 00 7d7c7f7e79787b7a
00005007 00000010 00000000 0000000000000000 0000000000000000 9 1 00 4d4c4f4e49484b4a
00000027 000000e0 00000000 0000000000000000 8877665544332211 c 1 00 0000000000000000
00000007 000000e0 00000000 0000000000000000 0000000000000000 9 1 00 8877665544332211
00000007 000000e8 00000000 0000000000000000 0000000000000000 1 1 00 00000000000000b2
# Width code 111 is rejected, memory must stay as it was
00007027 00000000 00000000 0000000000000000 ffffffffffffffff 4 1 00 0000000000000000
00007007 00000000 00000000 0000000000000000 0000000000000000 4 1 00 0000000000000000
00000007 00000000 00000000 0000000000000000 0000000000000000 8 1 00 5d5c5f5e59585b5a
# Empty requests
00000007 00000000 00000000 0000000000000000 0000000000000000 0 1 00 0000000000000000
00000027 00000040 00000000 0000000000000000 ffffffffffffffff 0 1 00 0000000000000000
00000007 00000040 00000000 0000000000000000 0000000000000000 2 1 00 0000000000001b1a

//--- bench/tb_vector_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_lsu_params.svh"

module tb_vector_lsu;

    localparam int    VLEN         = `VLSU_VLEN;
    localparam int    AW           = `VLSU_ADDR_WIDTH;
    localparam int    DW           = `VLSU_BUS_WIDTH;
    localparam int    BE           = `VLSU_BUS_WIDTH/8;
    localparam int    CW           = `VLSU_COUNT_WIDTH;
    localparam int    DONE_TIMEOUT = 40;
    localparam int    QUIET_CYCLES = 20;
    localparam string INPUT_FILE   = "bench/lsu_input.txt";

    logic                clk;
    logic                reset_n;
    logic                start_i;
    logic [31:0]         instruction_i;
    logic [AW-1:0]       base_address_i;
    logic [AW-1:0]       stride_i;
    logic [VLEN-1:0]     index_vector_i;
    logic [VLEN-1:0]     write_vector_i;
    logic [CW-1:0]       vl_i;
    logic                vm_i;
    logic [VLEN/8-1:0]   mask_i;
    logic                busy_o;
    logic                done_o;
    logic [VLEN-1:0]     read_data_o;
    logic [AW-1:0]       mem_address_o;
    logic                mem_read_enable_o;
    logic [BE-1:0]       mem_write_enable_o;
    logic [DW-1:0]       mem_write_data_o;
    logic [DW-1:0]       mem_read_data_i;

    // Current record from the stimulus file
    logic [31:0]         rec_instr;
    logic [AW-1:0]       rec_base;
    logic [AW-1:0]       rec_stride;
    logic [VLEN-1:0]     rec_index;
    logic [VLEN-1:0]     rec_wdata;
    logic [CW-1:0]       rec_vl;
    logic                rec_vm;
    logic [VLEN/8-1:0]   rec_mask;
    logic [VLEN-1:0]     rec_expected;

    // 256 bytes, only the low address bits decode
    logic [7:0]          mem [0:255];

    vector_lsu dut_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .start_i            (start_i),
        .instruction_i      (instruction_i),
        .base_address_i     (base_address_i),
        .stride_i           (stride_i),
        .index_vector_i     (index_vector_i),
        .write_vector_i     (write_vector_i),
        .vl_i               (vl_i),
        .vm_i               (vm_i),
        .mask_i             (mask_i),
        .busy_o             (busy_o),
        .done_o             (done_o),
        .read_data_o        (read_data_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o),
        .mem_read_data_i    (mem_read_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////

    // Read data one cycle after the request, byte-enabled writes
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int a = 0; a < 256; a++) begin
                mem[8'(a)] <= 8'(a) ^ 8'h5A;
            end
            mem_read_data_i <= '0;
        end else begin
            if (mem_read_enable_o) begin
                mem_read_data_i <= {mem[{mem_address_o[7:2], 2'd3}],
                                    mem[{mem_address_o[7:2], 2'd2}],
                                    mem[{mem_address_o[7:2], 2'd1}],
                                    mem[{mem_address_o[7:2], 2'd0}]};
            end
            for (int b = 0; b < BE; b++) begin
                if (mem_write_enable_o[2'(b)]) begin
                    mem[{mem_address_o[7:2], 2'(b)}] <= mem_write_data_o[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    task automatic clear_inputs();
        start_i        = 1'b0;
        instruction_i  = '0;
        base_address_i = '0;
        stride_i       = '0;
        index_vector_i = '0;
        write_vector_i = '0;
        vl_i           = '0;
        vm_i           = 1'b0;
        mask_i         = '0;
    endtask

    // Beats = min(vl, VLEN / element width)
    function automatic int beats_for(input logic [2:0] width_code, input logic [CW-1:0] vl);
        int capacity;
        case (width_code)
            3'b000:  capacity = VLEN / 8;
            3'b101:  capacity = VLEN / 16;
            default: capacity = VLEN / 32;
        endcase
        return (int'(vl) < capacity) ? int'(vl) : capacity;
    endfunction

    task automatic wait_for_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                stop_with_failure($sformatf("Timed out after %0d cycles waiting for done_o",
                                            DONE_TIMEOUT));
            end
            check_value("busy_o", 64'(busy_o), 64'd1);
        end while (!done_o);
    endtask

    // Rejected instruction, nothing may move
    task automatic check_quiet();
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(negedge clk);
            check_value("busy_o", 64'(busy_o), 64'd0);
            check_value("done_o", 64'(done_o), 64'd0);
            check_value("mem_read_enable_o", 64'(mem_read_enable_o), 64'd0);
            check_value("mem_write_enable_o", 64'(mem_write_enable_o), 64'd0);
        end
    endtask

    task automatic run_record();
        int n;
        int cycles;
        int expected_cycles;
        bit is_store;
        bit legal;

        is_store = (rec_instr[6:0] == 7'b0100111);
        legal    = (is_store || rec_instr[6:0] == 7'b0000111) &&
                   (rec_instr[14:12] == 3'b000 || rec_instr[14:12] == 3'b101 ||
                    rec_instr[14:12] == 3'b110);
        n        = beats_for(rec_instr[14:12], rec_vl);
        check_value("busy_o", 64'(busy_o), 64'd0);
        start_i        = 1'b1;
        instruction_i  = rec_instr;
        base_address_i = rec_base;
        stride_i       = rec_stride;
        index_vector_i = rec_index;
        write_vector_i = rec_wdata;
        vl_i           = rec_vl;
        vm_i           = rec_vm;
        mask_i         = rec_mask;
        @(posedge clk);
        #1;
        // Operands only count in the start cycle
        clear_inputs();
        if (!legal) begin
            check_quiet();
        end else begin
            if (n == 0) begin
                expected_cycles = 1;
            end else begin
                expected_cycles = is_store ? n + 1 : n + 2;
            end
            wait_for_done(cycles);
            check_value("done_o cycle", 64'(cycles), 64'(expected_cycles));
            if (!is_store) begin
                check_value("read_data_o", read_data_o, rec_expected);
            end
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    code;
        int    records;
        string line;

        reset_n = 1'b0;
        clear_inputs();
        records = 0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the stimulus file bench/lsu_input.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // Skip blank lines and column notes
            if (code > 1 && line.getc(0) != 8'h23) begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", rec_instr, rec_base,
                               rec_stride, rec_index, rec_wdata, rec_vl, rec_vm,
                               rec_mask, rec_expected);
                if (code != 9) begin
                    stop_with_failure($sformatf("Malformed stimulus line: %s", line));
                end
                run_record();
                records++;
            end
        end
        $fclose(fd);
        if (records == 0) begin
            stop_with_failure("No stimulus records were read");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog/vector_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_lsu_params.svh"

module vector_lsu (
    input  logic                          clk,
    input  logic                          reset_n,

    // Core side
    input  logic                          start_i,
    input  logic [31:0]                   instruction_i,
    input  logic [`VLSU_ADDR_WIDTH-1:0]   base_address_i,
    input  logic [`VLSU_ADDR_WIDTH-1:0]   stride_i,
    input  logic [`VLSU_VLEN-1:0]         index_vector_i,
    input  logic [`VLSU_VLEN-1:0]         write_vector_i,
    input  logic [`VLSU_COUNT_WIDTH-1:0]  vl_i,
    input  logic                          vm_i,
    input  logic [`VLSU_VLEN/8-1:0]       mask_i,
    output logic                          busy_o,
    output logic                          done_o,
    output logic [`VLSU_VLEN-1:0]         read_data_o,

    // Memory side
    output logic [`VLSU_ADDR_WIDTH-1:0]   mem_address_o,
    output logic                          mem_read_enable_o,
    output logic [`VLSU_BUS_WIDTH/8-1:0]  mem_write_enable_o,
    output logic [`VLSU_BUS_WIDTH-1:0]    mem_write_data_o,
    input  logic [`VLSU_BUS_WIDTH-1:0]    mem_read_data_i
);

    lsu_req_if  req_if ();
    lsu_beat_if beat_if ();

    lsu_decode decode_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .instruction_i  (instruction_i),
        .base_address_i (base_address_i),
        .stride_i       (stride_i),
        .index_vector_i (index_vector_i),
        .write_vector_i (write_vector_i),
        .vl_i           (vl_i),
        .vm_i           (vm_i),
        .mask_i         (mask_i),
        .busy_i         (busy_o),
        .req            (req_if.source)
    );

    lsu_sequencer sequencer_i (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req_if.sink),
        .beat    (beat_if.source),
        .busy_o  (busy_o),
        .done_o  (done_o)
    );

    lsu_store_lane store_lane_i (
        .req                (req_if.sink),
        .beat               (beat_if.sink),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    lsu_load_gather load_gather_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .req             (req_if.sink),
        .beat            (beat_if.sink),
        .mem_read_data_i (mem_read_data_i),
        .read_data_o     (read_data_o)
    );

    // Reads are issued for every load beat, masked or not
    assign mem_read_enable_o = beat_if.beat_valid && !req_if.is_store;
    assign mem_address_o     = beat_if.addr;

endmodule

`default_nettype wire

//--- verilog/lsu_load_gather.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_lsu_params.svh"

module lsu_load_gather (
    input  logic                         clk,
    input  logic                         reset_n,
    lsu_req_if.sink                      req,
    lsu_beat_if.sink                     beat,
    input  logic [`VLSU_BUS_WIDTH-1:0]   mem_read_data_i,
    output logic [`VLSU_VLEN-1:0]        read_data_o
);
    import vector_lsu_pkg::*;

    localparam int VLEN = `VLSU_VLEN;
    localparam int CW   = `VLSU_COUNT_WIDTH;
    localparam int LSBW = $clog2(`VLSU_BUS_WIDTH/8);
    localparam int IW8  = $clog2(VLEN/8);
    localparam int IW16 = $clog2(VLEN/16);
    localparam int IW32 = $clog2(VLEN/32);

    logic              pend_q;
    logic [CW-1:0]     idx_q;
    logic [LSBW-1:0]   lsb_q;
    logic [VLEN-1:0]   result_q;
    bus_word_u         rd_word;

    ////////////////////////////////////////////////////////////
    // Beat in flight
    ////////////////////////////////////////////////////////////

    // Inactive elements are never gathered, so their slots stay zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= beat.beat_valid && beat.active && !req.is_store;
        end
    end

    always_ff @(posedge clk) begin
        idx_q <= beat.elem_index;
        lsb_q <= beat.addr[LSBW-1:0];
    end

    ////////////////////////////////////////////////////////////
    // Result assembly
    ////////////////////////////////////////////////////////////

    assign rd_word = mem_read_data_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_q <= '0;
        end else if (req.req_valid && !req.is_store) begin
            result_q <= '0;
        end else if (pend_q) begin
            case (req.width)
                EW8:     result_q[8*idx_q[IW8-1:0] +: 8]    <= rd_word.bytes[lsb_q];
                EW16:    result_q[16*idx_q[IW16-1:0] +: 16] <= rd_word.halves[lsb_q[LSBW-1]];
                default: result_q[32*idx_q[IW32-1:0] +: 32] <= rd_word.bytes;
            endcase
        end
    end

    // Reads zero from the start cycle of a load, so an empty load is zero at done
    assign read_data_o = (req.req_valid && !req.is_store) ? '0 : result_q;

endmodule

`default_nettype wire

//--- verilog/lsu_store_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_lsu_params.svh"

module lsu_store_lane (
    lsu_req_if.sink                        req,
    lsu_beat_if.sink                       beat,
    output logic [`VLSU_BUS_WIDTH/8-1:0]   mem_write_enable_o,
    output logic [`VLSU_BUS_WIDTH-1:0]     mem_write_data_o
);
    import vector_lsu_pkg::*;

    localparam int VLEN   = `VLSU_VLEN;
    localparam int BE     = `VLSU_BUS_WIDTH/8;
    localparam int HALVES = `VLSU_BUS_WIDTH/16;
    localparam int LSBW   = $clog2(BE);
    localparam int IW8    = $clog2(VLEN/8);
    localparam int IW16   = $clog2(VLEN/16);
    localparam int IW32   = $clog2(VLEN/32);

    logic [VLEN/8-1:0][7:0]     wv8;
    logic [VLEN/16-1:0][15:0]   wv16;
    logic [VLEN/32-1:0][31:0]   wv32;
    logic [LSBW-1:0]            lsb;
    logic [BE-1:0]              byte_en;
    bus_word_u                  wr_word;

    assign wv8  = req.write_vector;
    assign wv16 = req.write_vector;
    assign wv32 = req.write_vector;
    assign lsb  = beat.addr[LSBW-1:0];

    // Element copied to every lane, enables pick the addressed one
    always_comb begin
        wr_word = '0;
        byte_en = '0;
        case (req.width)
            EW8: begin
                wr_word.bytes = {BE{wv8[beat.elem_index[IW8-1:0]]}};
                byte_en       = BE'(1) << lsb;
            end
            EW16: begin
                wr_word.halves = {HALVES{wv16[beat.elem_index[IW16-1:0]]}};
                byte_en        = BE'(2'b11) << {lsb[LSBW-1], 1'b0};
            end
            default: begin
                wr_word.bytes = wv32[beat.elem_index[IW32-1:0]];
                byte_en       = '1;
            end
        endcase
    end

    // Masked-off elements and loads write nothing
    assign mem_write_enable_o = (beat.beat_valid && beat.active && req.is_store) ?
                                byte_en : '0;
    assign mem_write_data_o   = wr_word;

endmodule

`default_nettype wire

//--- verilog/lsu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_lsu_params.svh"

module lsu_sequencer (
    input  logic        clk,
    input  logic        reset_n,
    lsu_req_if.sink     req,
    lsu_beat_if.source  beat,
    output logic        busy_o,
    output logic        done_o
);
    import vector_lsu_pkg::*;

    localparam int VLEN = `VLSU_VLEN;
    localparam int AW   = `VLSU_ADDR_WIDTH;
    localparam int CW   = `VLSU_COUNT_WIDTH;
    localparam int IW8  = $clog2(VLEN/8);
    localparam int IW16 = $clog2(VLEN/16);
    localparam int IW32 = $clog2(VLEN/32);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_e;

    seq_state_e                 state_q;
    logic [CW-1:0]              elem_q;
    logic [AW-1:0]              stride_off_q;
    logic                       done_q;

    logic [CW-1:0]              capacity;
    logic [CW-1:0]              beat_count;
    logic [CW-1:0]              cur_idx;
    logic [AW-1:0]              cur_stride_off;
    logic [AW-1:0]              offset;
    logic                       issuing;
    logic                       is_last;
    logic [VLEN/8-1:0][7:0]     iv8;
    logic [VLEN/16-1:0][15:0]   iv16;
    logic [VLEN/32-1:0][31:0]   iv32;

    ////////////////////////////////////////////////////////////
    // Element count and index
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req.width)
            EW8:     capacity = CW'(VLEN/8);
            EW16:    capacity = CW'(VLEN/16);
            default: capacity = CW'(VLEN/32);
        endcase
        beat_count = (req.vl < capacity) ? req.vl : capacity;
    end

    // First beat goes out with req_valid, before the FSM leaves idle
    assign cur_idx        = (state_q == SEQ_ISSUE) ? elem_q : '0;
    assign cur_stride_off = (state_q == SEQ_ISSUE) ? stride_off_q : '0;
    assign issuing        = (state_q == SEQ_ISSUE) ||
                            (state_q == SEQ_IDLE && req.req_valid && beat_count != '0);
    assign is_last        = (cur_idx == beat_count - 1'b1);

    ////////////////////////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////////////////////////

    assign iv8  = req.index_vector;
    assign iv16 = req.index_vector;
    assign iv32 = req.index_vector;

    always_comb begin
        case (req.mode)
            UNIT_STRIDED: begin
                case (req.width)
                    EW8:     offset = AW'(cur_idx);
                    EW16:    offset = AW'(cur_idx) << 1;
                    default: offset = AW'(cur_idx) << 2;
                endcase
            end
            STRIDED: offset = cur_stride_off;
            default: begin
                // Index element read at the data width
                case (req.width)
                    EW8:     offset = AW'(iv8[cur_idx[IW8-1:0]]);
                    EW16:    offset = AW'(iv16[cur_idx[IW16-1:0]]);
                    default: offset = AW'(iv32[cur_idx[IW32-1:0]]);
                endcase
            end
        endcase
    end

    assign beat.beat_valid = issuing;
    assign beat.elem_index = cur_idx;
    assign beat.addr       = req.base + offset;
    assign beat.last       = issuing && is_last;
    assign beat.active     = req.vm || req.mask[cur_idx[IW8-1:0]];

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q      <= SEQ_IDLE;
            elem_q       <= '0;
            stride_off_q <= '0;
            done_q       <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (issuing) begin
                elem_q       <= cur_idx + 1'b1;
                stride_off_q <= cur_stride_off + req.stride;
                if (!is_last) begin
                    state_q <= SEQ_ISSUE;
                end else if (req.is_store) begin
                    state_q <= SEQ_IDLE;
                    done_q  <= 1'b1;
                end else begin
                    // Last load beat still has its data in flight
                    state_q <= SEQ_DRAIN;
                end
            end else if (state_q == SEQ_DRAIN) begin
                state_q <= SEQ_IDLE;
                done_q  <= 1'b1;
            end
        end
    end

    // Zero-length request completes right away
    assign done_o = done_q ||
                    (state_q == SEQ_IDLE && req.req_valid && beat_count == '0);
    assign busy_o = req.req_valid || (state_q != SEQ_IDLE) || done_q;

endmodule

`default_nettype wire

//--- verilog/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_lsu_params.svh"

module lsu_decode (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  logic [31:0]                   instruction_i,
    input  logic [`VLSU_ADDR_WIDTH-1:0]   base_address_i,
    input  logic [`VLSU_ADDR_WIDTH-1:0]   stride_i,
    input  logic [`VLSU_VLEN-1:0]         index_vector_i,
    input  logic [`VLSU_VLEN-1:0]         write_vector_i,
    input  logic [`VLSU_COUNT_WIDTH-1:0]  vl_i,
    input  logic                          vm_i,
    input  logic [`VLSU_VLEN/8-1:0]       mask_i,
    input  logic                          busy_i,
    lsu_req_if.source                     req
);
    import vector_lsu_pkg::*;

    localparam logic [6:0] LOAD_OPCODE  = 7'b0000111;
    localparam logic [6:0] STORE_OPCODE = 7'b0100111;

    logic        opcode_ok;
    logic        width_ok;
    logic        accept;
    elem_width_e width_dec;

    assign opcode_ok = (instruction_i[6:0] == LOAD_OPCODE) ||
                       (instruction_i[6:0] == STORE_OPCODE);

    // Only 8, 16 and 32 bit element widths
    always_comb begin
        width_ok  = 1'b1;
        width_dec = EW8;
        case (instruction_i[14:12])
            3'b000:  width_dec = EW8;
            3'b101:  width_dec = EW16;
            3'b110:  width_dec = EW32;
            default: width_ok  = 1'b0;
        endcase
    end

    assign accept = start_i && !busy_i && opcode_ok && width_ok;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req.req_valid <= 1'b0;
            req.is_store  <= 1'b0;
            req.width     <= EW8;
            req.mode      <= UNIT_STRIDED;
        end else begin
            req.req_valid <= accept;
            if (accept) begin
                req.is_store <= (instruction_i[6:0] == STORE_OPCODE);
                req.width    <= width_dec;
                req.mode     <= addr_mode_e'(instruction_i[27:26]);
            end
        end
    end

    // Operands
    always_ff @(posedge clk) begin
        if (accept) begin
            req.base         <= base_address_i;
            req.stride       <= stride_i;
            req.index_vector <= index_vector_i;
            req.write_vector <= write_vector_i;
            req.vl           <= vl_i;
            req.vm           <= vm_i;
            req.mask         <= mask_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_lsu_params.svh"

// Accepted request, operands held until the next accepted start
interface lsu_req_if;
    import vector_lsu_pkg::*;

    logic                          req_valid;
    logic                          is_store;
    elem_width_e                   width;
    addr_mode_e                    mode;
    logic [`VLSU_ADDR_WIDTH-1:0]   base;
    logic [`VLSU_ADDR_WIDTH-1:0]   stride;
    logic [`VLSU_VLEN-1:0]         index_vector;
    logic [`VLSU_VLEN-1:0]         write_vector;
    logic [`VLSU_COUNT_WIDTH-1:0]  vl;
    logic                          vm;
    logic [`VLSU_VLEN/8-1:0]       mask;

    modport source (output req_valid, is_store, width, mode, base, stride,
                    index_vector, write_vector, vl, vm, mask);
    modport sink   (input  req_valid, is_store, width, mode, base, stride,
                    index_vector, write_vector, vl, vm, mask);
endinterface

// One element access, consumed in the cycle it is valid
interface lsu_beat_if;
    logic                          beat_valid;
    logic [`VLSU_COUNT_WIDTH-1:0]  elem_index;
    logic [`VLSU_ADDR_WIDTH-1:0]   addr;
    logic                          last;
    logic                          active;

    modport source (output beat_valid, elem_index, addr, last, active);
    modport sink   (input  beat_valid, elem_index, addr, last, active);
endinterface

`default_nettype wire

//--- verilog/vector_lsu_pkg.sv
`default_nettype none

`include "vector_lsu_params.svh"

package vector_lsu_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    // Encoded as the shift from element index to byte offset
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } elem_width_e;

    // The mop field, bits 27:26
    typedef enum logic [1:0] {
        UNIT_STRIDED      = 2'b00,
        INDEXED_UNORDERED = 2'b01,
        STRIDED           = 2'b10,
        INDEXED_ORDERED   = 2'b11
    } addr_mode_e;

    ////////////////////////////////////////////////////////////
    // Bus word views
    ////////////////////////////////////////////////////////////

    // Byte lanes for 8-bit elements, halfword lanes for 16-bit ones
    typedef union packed {
        logic [`VLSU_BUS_WIDTH/8-1:0][7:0]   bytes;
        logic [`VLSU_BUS_WIDTH/16-1:0][15:0] halves;
    } bus_word_u;

endpackage

`default_nettype wire

//--- verilog/vector_lsu_params.svh
`ifndef VECTOR_LSU_PARAMS_SVH
`define VECTOR_LSU_PARAMS_SVH

// Vector register width in bits
`define VLSU_VLEN 64

// Memory data bus width
`define VLSU_BUS_WIDTH 32

// Byte address width
`define VLSU_ADDR_WIDTH 32

// Element index and vl width, enough for VLEN/8 elements plus clipping
`define VLSU_COUNT_WIDTH 4

`endif
